/* source/ctr_pkg.sv */
////////////////////////////////////////
// Counter increment engine package
// FSM state encoding, APB register map
// and command codes
////////////////////////////////////////

package ctr_pkg;

  ////////////////////////////////////////
  // FSM state encoding
  ////////////////////////////////////////

  // Sparse 6-bit code, pairwise Hamming distance of four
  typedef enum logic [5:0] {
    CTR_IDLE  = 6'b011101,
    CTR_INCR  = 6'b110000,
    CTR_ERROR = 6'b001010
  } ctr_state_e;

  ////////////////////////////////////////
  // APB register map
  ////////////////////////////////////////

  parameter int ApbAddrWidth = 8;

  // Counter words, word 0 holds the least significant bits
  parameter logic [ApbAddrWidth-1:0] CtrWord0Offset = 8'h00;
  parameter logic [ApbAddrWidth-1:0] CtrWord1Offset = 8'h04;
  parameter logic [ApbAddrWidth-1:0] CtrWord2Offset = 8'h08;
  parameter logic [ApbAddrWidth-1:0] CtrWord3Offset = 8'h0C;

  // Write-only command and read-only status
  parameter logic [ApbAddrWidth-1:0] CmdOffset      = 8'h10;
  parameter logic [ApbAddrWidth-1:0] StatusOffset   = 8'h14;

  // Command codes, any other nonzero code is illegal
  parameter logic [3:0] CmdNop  = 4'h0;
  parameter logic [3:0] CmdIncr = 4'hA;

endpackage

/* source/ctr_apb_regs.sv */
////////////////////////////////////////
// APB register block of the counter
// increment engine. Decodes word writes,
// commands and status reads, flags errors
////////////////////////////////////////

`timescale 1ns/1ps

module ctr_apb_regs #(
  parameter int CtrWidth = 128
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // APB slave
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [ctr_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic [31:0]                      pwdata_i,
  output logic [31:0]                      prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,

  // FSM status
  input  logic                             ready_i,
  input  logic                             alert_i,

  // Counter storage
  input  logic [CtrWidth-1:0]              ctr_words_i,
  output logic                             word_we_o,
  output logic [1:0]                       word_idx_o,
  output logic [31:0]                      word_data_o,

  // FSM requests, one-cycle pulses
  output logic                             incr_o,
  output logic                             incr_err_o
);

  import ctr_pkg::*;

  localparam int NumWords = CtrWidth / 32;

  logic        access;
  logic        wr_access;
  logic        rd_access;
  logic        is_word;
  logic        is_cmd;
  logic        is_status;
  logic        unmapped;
  logic [1:0]  addr_idx;
  logic        busy;
  logic        wr_err;
  logic        cmd_we;
  logic [3:0]  cmd_code;
  logic        incr_q;
  logic        incr_err_q;
  logic [31:0] words [NumWords];

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  // Access phase only, slave never stalls
  assign access    = psel_i & penable_i;
  assign wr_access = access & pwrite_i;
  assign rd_access = access & ~pwrite_i;

  always_comb begin
    is_word   = 1'b0;
    is_cmd    = 1'b0;
    is_status = 1'b0;
    addr_idx  = 2'd0;
    case (paddr_i)
      CtrWord0Offset: begin
        is_word  = 1'b1;
        addr_idx = 2'd0;
      end
      CtrWord1Offset: begin
        is_word  = 1'b1;
        addr_idx = 2'd1;
      end
      CtrWord2Offset: begin
        is_word  = 1'b1;
        addr_idx = 2'd2;
      end
      CtrWord3Offset: begin
        is_word  = 1'b1;
        addr_idx = 2'd3;
      end
      CmdOffset:    is_cmd    = 1'b1;
      StatusOffset: is_status = 1'b1;
      default:      is_word   = 1'b0;
    endcase
    // Words above a narrower counter are not mapped
    if (int'(addr_idx) >= NumWords) begin
      is_word = 1'b0;
    end
  end

  assign unmapped = ~(is_word | is_cmd | is_status);

  ////////////////////////////////////////
  // Write checks and forwarding
  ////////////////////////////////////////

  // Busy also while a request pulse is still on its way to the FSM
  assign busy   = ~ready_i | incr_q | incr_err_q;
  assign wr_err = alert_i | unmapped | is_status | ((is_word | is_cmd) & busy);

  // Reads fail only on unmapped addresses
  assign pready_o  = 1'b1;
  assign pslverr_o = access & (pwrite_i ? wr_err : unmapped);

  // Counter word writes go straight to storage
  assign word_we_o   = wr_access & is_word & ~wr_err;
  assign word_idx_o  = addr_idx;
  assign word_data_o = pwdata_i;

  // Command decode
  assign cmd_we   = wr_access & is_cmd & ~wr_err;
  assign cmd_code = pwdata_i[3:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      incr_q     <= 1'b0;
      incr_err_q <= 1'b0;
    end else begin
      incr_q     <= cmd_we & (cmd_code == CmdIncr);
      incr_err_q <= cmd_we & (cmd_code != CmdIncr) & (cmd_code != CmdNop);
    end
  end

  assign incr_o     = incr_q;
  assign incr_err_o = incr_err_q;

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  // Split counter into 32-bit words
  for (genvar w = 0; w < NumWords; w++) begin : g_words
    assign words[w] = ctr_words_i[32*w +: 32];
  end

  always_comb begin
    prdata_o = '0;
    if (rd_access && is_word) begin
      prdata_o = words[addr_idx];
    end else if (rd_access && is_status) begin
      // Bit 0 ready, bit 1 alert
      prdata_o = {30'd0, alert_i, ~busy};
    end
  end

endmodule

/* source/ctr_slice_reg.sv */
////////////////////////////////////////
// Counter storage, written by APB words
// and by FSM slices, read slice-wise
////////////////////////////////////////

`timescale 1ns/1ps

module ctr_slice_reg #(
  parameter int CtrWidth  = 128,
  parameter int SliceSize = 16,
  localparam int NumSlices     = CtrWidth / SliceSize,
  localparam int SliceIdxWidth = (NumSlices > 1) ? $clog2(NumSlices) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // APB word write
  input  logic                     word_we_i,
  input  logic [1:0]               word_idx_i,
  input  logic [31:0]              word_data_i,

  // FSM slice access
  input  logic [SliceIdxWidth-1:0] slice_idx_i,
  input  logic                     slice_we_i,
  input  logic [SliceSize-1:0]     slice_wdata_i,
  output logic [SliceSize-1:0]     slice_rdata_o,

  // Whole counter for APB reads
  output logic [CtrWidth-1:0]      ctr_words_o
);

  logic [CtrWidth-1:0] ctr_q;

  // Counter flops
  // APB writes are rejected while the FSM runs, so ports never collide
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q <= '0;
    end else begin
      if (word_we_i) begin
        ctr_q[32*word_idx_i +: 32] <= word_data_i;
      end
      if (slice_we_i) begin
        ctr_q[SliceSize*slice_idx_i +: SliceSize] <= slice_wdata_i;
      end
    end
  end

  // Combinational slice select
  assign slice_rdata_o = ctr_q[SliceSize*slice_idx_i +: SliceSize];

  assign ctr_words_o = ctr_q;

endmodule

/* source/ctr_incr_fsm.sv */
////////////////////////////////////////
// Counter increment FSM. Adds one slice
// per cycle with carry, sparse states,
// terminal error state with alert
////////////////////////////////////////

`timescale 1ns/1ps

module ctr_incr_fsm #(
  parameter int CtrWidth  = 128,
  parameter int SliceSize = 16,
  localparam int NumSlices     = CtrWidth / SliceSize,
  localparam int SliceIdxWidth = (NumSlices > 1) ? $clog2(NumSlices) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Requests from the APB block
  input  logic                     incr_i,
  input  logic                     incr_err_i,
  output logic                     ready_o,
  output logic                     alert_o,

  // Slice access to counter storage
  output logic [SliceIdxWidth-1:0] slice_idx_o,
  input  logic [SliceSize-1:0]     slice_rdata_i,
  output logic [SliceSize-1:0]     slice_wdata_o,
  output logic                     slice_we_o
);

  import ctr_pkg::*;

  localparam logic [SliceIdxWidth-1:0] LastSlice = SliceIdxWidth'(NumSlices - 1);

  ctr_state_e               state_d, state_q;
  logic [SliceIdxWidth-1:0] slice_idx_d, slice_idx_q;
  logic                     carry_d, carry_q;
  logic [SliceSize:0]       sum;

  ////////////////////////////////////////
  // Slice adder
  ////////////////////////////////////////

  // Extra top bit is the carry-out
  assign sum           = {1'b0, slice_rdata_i} + {{SliceSize{1'b0}}, carry_q};
  assign slice_wdata_o = sum[SliceSize-1:0];

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_comb begin
    ready_o     = 1'b0;
    alert_o     = 1'b0;
    slice_we_o  = 1'b0;
    state_d     = state_q;
    slice_idx_d = slice_idx_q;
    carry_d     = carry_q;

    case (state_q)
      CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Start at the low slice, adding one
          slice_idx_d = '0;
          carry_d     = 1'b1;
          state_d     = CTR_INCR;
        end
      end

      CTR_INCR: begin
        slice_we_o  = 1'b1;
        slice_idx_d = slice_idx_q + 1'b1;
        carry_d     = sum[SliceSize];
        // Done after the top slice, final carry drops out (wrap)
        if (slice_idx_q == LastSlice) begin
          state_d = CTR_IDLE;
        end
      end

      CTR_ERROR: begin
        // Terminal, only reset leaves
        alert_o = 1'b1;
      end

      default: begin
        // Illegal encoding, trap immediately
        alert_o = 1'b1;
        state_d = CTR_ERROR;
      end
    endcase

    // Illegal command overrides everything
    if (incr_err_i) begin
      state_d = CTR_ERROR;
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= CTR_IDLE;
      slice_idx_q <= '0;
      carry_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      slice_idx_q <= slice_idx_d;
      carry_q     <= carry_d;
    end
  end

  assign slice_idx_o = slice_idx_q;

endmodule

/* source/ctr_incr_top.sv */
////////////////////////////////////////
// Counter increment engine top level
// APB register block, counter storage
// and increment FSM
////////////////////////////////////////

`timescale 1ns/1ps

module ctr_incr_top #(
  // Multiple of 32 and of SliceSize
  parameter int CtrWidth  = 128,
  parameter int SliceSize = 16
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // APB slave
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [ctr_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic [31:0]                      pwdata_i,
  output logic [31:0]                      prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,

  // Sticky error alert
  output logic                             alert_o
);

  localparam int NumSlices     = CtrWidth / SliceSize;
  localparam int SliceIdxWidth = (NumSlices > 1) ? $clog2(NumSlices) : 1;

  // APB block to storage
  logic                     word_we;
  logic [1:0]               word_idx;
  logic [31:0]              word_data;
  logic [CtrWidth-1:0]      ctr_words;

  // APB block and FSM handshake
  logic                     incr;
  logic                     incr_err;
  logic                     ready;
  logic                     alert;

  // FSM to storage
  logic [SliceIdxWidth-1:0] slice_idx;
  logic                     slice_we;
  logic [SliceSize-1:0]     slice_wdata;
  logic [SliceSize-1:0]     slice_rdata;

  ////////////////////////////////////////
  // Submodules
  ////////////////////////////////////////

  ctr_apb_regs #(
    .CtrWidth    (CtrWidth)
  ) u_apb_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .ready_i     (ready),
    .alert_i     (alert),
    .ctr_words_i (ctr_words),
    .word_we_o   (word_we),
    .word_idx_o  (word_idx),
    .word_data_o (word_data),
    .incr_o      (incr),
    .incr_err_o  (incr_err)
  );

  ctr_slice_reg #(
    .CtrWidth      (CtrWidth),
    .SliceSize     (SliceSize)
  ) u_slice_reg (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .word_we_i     (word_we),
    .word_idx_i    (word_idx),
    .word_data_i   (word_data),
    .slice_idx_i   (slice_idx),
    .slice_we_i    (slice_we),
    .slice_wdata_i (slice_wdata),
    .slice_rdata_o (slice_rdata),
    .ctr_words_o   (ctr_words)
  );

  ctr_incr_fsm #(
    .CtrWidth      (CtrWidth),
    .SliceSize     (SliceSize)
  ) u_incr_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .incr_i        (incr),
    .incr_err_i    (incr_err),
    .ready_o       (ready),
    .alert_o       (alert),
    .slice_idx_o   (slice_idx),
    .slice_rdata_i (slice_rdata),
    .slice_wdata_o (slice_wdata),
    .slice_we_o    (slice_we)
  );

  assign alert_o = alert;

endmodule

/* verification/ctr_model.svh */
////////////////////////////////////////
// Counter engine reference model
// Reference counter, expected status
// and APB master tasks
////////////////////////////////////////

`ifndef CTR_MODEL_SVH
`define CTR_MODEL_SVH

// Reference counter, word 0 in the low bits
logic [127:0] ref_ctr;
// Set once an illegal command is accepted
logic         exp_alert;

// Idle status, ready is gone for good after an alert
function automatic logic [31:0] expected_status(input logic alert_seen);
  return {30'd0, alert_seen, ~alert_seen};
endfunction

// APB offset of a counter word
function automatic logic [ApbAddrWidth-1:0] word_addr(input int idx);
  case (idx)
    0:       return CtrWord0Offset;
    1:       return CtrWord1Offset;
    2:       return CtrWord2Offset;
    default: return CtrWord3Offset;
  endcase
endfunction

////////////////////////////////////////
// APB master
////////////////////////////////////////

// Setup phase, access phase, sample mid-cycle, then idle
task automatic apb_write(input logic [ApbAddrWidth-1:0] addr, input logic [31:0] data,
                         output logic err);
  @(posedge clk_i);
  psel_i    <= 1'b1;
  penable_i <= 1'b0;
  pwrite_i  <= 1'b1;
  paddr_i   <= addr;
  pwdata_i  <= data;
  @(posedge clk_i);
  penable_i <= 1'b1;
  @(negedge clk_i);
  err = pslverr_o;
  @(posedge clk_i);
  psel_i    <= 1'b0;
  penable_i <= 1'b0;
endtask

task automatic apb_read(input logic [ApbAddrWidth-1:0] addr, output logic [31:0] data,
                        output logic err);
  @(posedge clk_i);
  psel_i    <= 1'b1;
  penable_i <= 1'b0;
  pwrite_i  <= 1'b0;
  paddr_i   <= addr;
  @(posedge clk_i);
  penable_i <= 1'b1;
  // Read data is combinational in the access phase
  @(negedge clk_i);
  data = prdata_o;
  err  = pslverr_o;
  @(posedge clk_i);
  psel_i    <= 1'b0;
  penable_i <= 1'b0;
endtask

`endif

/* verification/ctr_incr_tb.sv */
////////////////////////////////////////
// Testbench of the counter increment
// engine, random counters against a model
////////////////////////////////////////

`timescale 1ns/1ps

module ctr_incr_tb;

  import ctr_pkg::*;

  localparam int NumLoadTrials = 4;
  localparam int NumTrials     = 200;
  localparam int NumBusyTrials = 8;
  localparam int MaxPolls      = 20;
  localparam int MaxAlertWait  = 20;
  // Reset, loads, increments, busy writes, rejected writes, error test
  localparam int NumOps     = 1 + NumLoadTrials + NumTrials + NumBusyTrials + 2 + 1;
  localparam int CycleLimit = 300 * NumOps;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    psel_i;
  logic                    penable_i;
  logic                    pwrite_i;
  logic [ApbAddrWidth-1:0] paddr_i;
  logic [31:0]             pwdata_i;
  logic [31:0]             prdata_o;
  logic                    pready_o;
  logic                    pslverr_o;
  logic                    alert_o;
  integer                  seed;

  `include "ctr_model.svh"

  ctr_incr_top #(
    .CtrWidth  (128),
    .SliceSize (16)
  ) dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .alert_o   (alert_o)
  );

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////

  // Stop at the first error
  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [127:0] random_counter();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // Write all four words and take them into the model
  task automatic load_counter(input logic [127:0] value);
    logic err;
    for (int w = 0; w < 4; w++) begin
      apb_write(word_addr(w), value[32*w +: 32], err);
      check_value("pslverr_o", {31'd0, err}, 32'd0);
    end
    ref_ctr = value;
  endtask

  task automatic check_counter();
    logic [31:0] data;
    logic        err;
    for (int w = 0; w < 4; w++) begin
      apb_read(word_addr(w), data, err);
      check_value($sformatf("prdata_o word %0d", w), data, ref_ctr[32*w +: 32]);
      check_value("pslverr_o", {31'd0, err}, 32'd0);
    end
  endtask

  // Poll status until ready, bounded
  task automatic wait_ready();
    logic [31:0] status;
    logic        err;
    int          polls;
    polls  = 0;
    status = '0;
    while (status[0] !== 1'b1) begin
      assert (polls < MaxPolls) else begin
        $display("Ready did not return within %0d status polls", MaxPolls);
        abort_run();
      end
      apb_read(StatusOffset, status, err);
      polls++;
    end
    check_value("status", status, expected_status(exp_alert));
  endtask

  task automatic run_increment();
    logic err;
    apb_write(CmdOffset, {28'd0, CmdIncr}, err);
    check_value("pslverr_o", {31'd0, err}, 32'd0);
    // Wraps to zero from all ones
    ref_ctr = ref_ctr + 128'd1;
    wait_ready();
  endtask

  // Cycle budget for the whole run
  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      assert (cycles < CycleLimit) else begin
        $display("Timeout, run exceeded %0d cycles", CycleLimit);
        abort_run();
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    logic [127:0]            value;
    logic [31:0]             r;
    logic [31:0]             data;
    logic                    err;
    int                      ones;
    logic [ApbAddrWidth-1:0] addr;
    logic [3:0]              code;
    seed      = 32'ha8fe_185d;
    rst_ni    = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    ref_ctr   = '0;
    exp_alert = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset values
    @(negedge clk_i);
    check_value("alert_o", {31'd0, alert_o}, 32'd0);
    check_value("pready_o", {31'd0, pready_o}, 32'd1);
    check_value("pslverr_o", {31'd0, pslverr_o}, 32'd0);
    apb_read(StatusOffset, data, err);
    check_value("status", data, expected_status(1'b0));
    check_counter();

    // Word write and read back
    for (int i = 0; i < NumLoadTrials; i++) begin
      load_counter(random_counter());
      check_counter();
    end

    // Increments, low words often all ones for long carry chains
    for (int i = 0; i < NumTrials; i++) begin
      value = random_counter();
      r     = $random(seed);
      ones  = (r[2:0] > 3'd4) ? 0 : int'(r[2:0]);
      for (int w = 0; w < ones; w++) begin
        value[32*w +: 32] = '1;
      end
      if (r[3]) begin
        value[15:0] = 16'hFFFF;
      end
      load_counter(value);
      run_increment();
      check_counter();
    end

    // Writes while busy are rejected
    for (int i = 0; i < NumBusyTrials; i++) begin
      load_counter(random_counter());
      r = $random(seed);
      apb_write(CmdOffset, {28'd0, CmdIncr}, err);
      check_value("pslverr_o", {31'd0, err}, 32'd0);
      ref_ctr = ref_ctr + 128'd1;
      if (r[0]) begin
        apb_write(word_addr(int'(r[2:1])), $random(seed), err);
      end else begin
        apb_write(CmdOffset, {28'd0, CmdIncr}, err);
      end
      check_value("pslverr_o", {31'd0, err}, 32'd1);
      wait_ready();
      check_counter();
    end

    // Status and unmapped writes, then a NOP command
    r = $random(seed);
    apb_write(StatusOffset, $random(seed), err);
    check_value("pslverr_o", {31'd0, err}, 32'd1);
    addr = {r[5:0], 2'b00};
    if (addr < 8'h18) begin
      addr = addr + 8'h40;
    end
    apb_write(addr, $random(seed), err);
    check_value("pslverr_o", {31'd0, err}, 32'd1);
    apb_write(CmdOffset, {28'd0, CmdNop}, err);
    check_value("pslverr_o", {31'd0, err}, 32'd0);
    repeat (4) @(posedge clk_i);
    apb_read(StatusOffset, data, err);
    check_value("status", data, expected_status(exp_alert));
    check_counter();

    // Illegal command, sticky alert
    r    = $random(seed);
    code = r[3:0];
    if (code == CmdNop || code == CmdIncr) begin
      code = code ^ 4'h5;
    end
    apb_write(CmdOffset, {r[31:4], code}, err);
    check_value("pslverr_o", {31'd0, err}, 32'd0);
    exp_alert = 1'b1;
    for (int c = 0; alert_o !== 1'b1; c++) begin
      assert (c < MaxAlertWait) else begin
        $display("Alert did not rise after an illegal command");
        abort_run();
      end
      @(negedge clk_i);
    end
    apb_read(StatusOffset, data, err);
    check_value("status", data, expected_status(exp_alert));
    for (int w = 0; w < 4; w++) begin
      apb_write(word_addr(w), $random(seed), err);
      check_value("pslverr_o", {31'd0, err}, 32'd1);
    end
    apb_write(CmdOffset, {28'd0, CmdIncr}, err);
    check_value("pslverr_o", {31'd0, err}, 32'd1);
    apb_write(StatusOffset, $random(seed), err);
    check_value("pslverr_o", {31'd0, err}, 32'd1);
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    check_value("alert_o", {31'd0, alert_o}, 32'd1);
    apb_read(StatusOffset, data, err);
    check_value("status", data, expected_status(exp_alert));
    check_counter();

    $display("All checks passed");
    $finish;
  end

endmodule

/* build.f */
source/ctr_pkg.sv
source/ctr_apb_regs.sv
source/ctr_slice_reg.sv
source/ctr_incr_fsm.sv
source/ctr_incr_top.sv
+incdir+verification
verification/ctr_incr_tb.sv

/* Makefile */
# Verilator build, run and lint for the counter increment engine

VERILATOR  ?= verilator
TOP        ?= ctr_incr_tb
LINT_TOP   ?= ctr_incr_top
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= All checks passed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides pass or fail, not the simulator exit code
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		{ echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
